/* tests/ldpc_input.txt */
// ROM image, one 16-bit hex word per line, @ sets the word address
// words at 1ff0: mode, iter_limit, expected group count, expected iteration toggles
@0003
8040 // pointer: long frame, schedule at 040
@0040
0205 // group 0: depth 2, q 05
1203
3417
5659
0110 // group 1: depth 1, q 10
0a2c
7800
2320 // group 2: last group, depth 3, q 20
2b43
1916
4e2d
0159
0000 // read during the drain
@1ff0
0003
0002
0003
0003

/* sim.f */
hdl/ldpc_ctrl_pkg.sv
hdl/ldpc_group_regs.sv
hdl/ldpc_schedule_fsm.sv
hdl/ldpc_latency_align.sv
hdl/ldpc_shift_split.sv
hdl/ldpc_iocontrol.sv
tests/ldpc_iocontrol_assertions.sv
tests/ldpc_iocontrol_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

log=sim.log
build_dir=obj_dir

verilator --binary --timing --assert -f sim.f \
  --top-module ldpc_iocontrol_tb --Mdir "$build_dir" -o sim_bin
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$build_dir/sim_bin" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
  echo "failures reported, see $log"
  exit 1
fi

echo "no failures reported"
exit 0

/* tests/ldpc_iocontrol_tb.sv */
`timescale 1ns/10ps

module ldpc_iocontrol_tb
  import ldpc_ctrl_pkg::*;
();

  localparam int ROM_WORDS = 2 ** ROM_AW;
  // test configuration sits at the top of the ROM image
  localparam int CFG_BASE  = ROM_WORDS - 16;
  localparam int RUNS      = 2;

  logic              clk;
  logic              rst;
  logic              start;
  logic [4:0]        mode;
  logic [5:0]        iter_limit;
  logic              done;
  logic              iteration;
  logic              first_iteration;
  logic              first_half;
  logic              we_vnmsg;
  logic [VN_AW-1:0]  addr_vn;
  logic              disable_vn;
  logic              cn_we;
  logic              cn_rd;
  logic [CN_AW-1:0]  addr_cn;
  logic              disable_cn;
  shift_ctrl_t       shifts;
  logic [ROM_AW-1:0] romaddr;
  rom_word_u         romdata = '0;

  logic [ROM_DW-1:0] rom [ROM_WORDS];
  int                exp_groups;
  int                exp_iters;
  int                exp_vn_start;
  bit                cfg_loaded = 1'b0;
  int                run_errors = 0;
  int                watch_errors = 0;
  int                iter_toggles = 0;
  int                first_iter_falls = 0;
  int                done_rises = 0;
  int                disable_vn_count = 0;
  int                disable_cn_count = 0;
  bit                cn_seen = 1'b0;
  logic [CN_AW-1:0]  cn_last = '0;
  logic [1:0]        shift0_d1 = '0;
  logic [1:0]        shift0_d2 = '0;
  logic              prev_iteration = 1'b0;
  logic              prev_first_iter = 1'b0;
  logic              prev_done = 1'b0;

  ldpc_iocontrol dut_i (.*);

  bind ldpc_iocontrol ldpc_iocontrol_assertions assertions_i (.*);

  always #10 clk = ~clk;

  // one-cycle registered ROM
  always @(posedge clk)
    romdata <= rom[romaddr];

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp, inout int errs);
    assert (got === exp)
    else
    begin
      errs++;
      $display("Fail %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_limit(input string name, input int got, input int limit,
                             inout int errs);
    assert (got <= limit)
    else
    begin
      errs++;
      $display("Fail %s: got %h, limit %h", name, got, limit);
    end
  endtask

  task automatic check_rule(input logic ok, input string what, inout int errs);
    assert (ok === 1'b1)
    else
    begin
      errs++;
      $display("%s", what);
    end
  endtask

  // first shift value of each stage-0 bin
  function automatic int bin_start(input logic [1:0] bin);
    case (bin)
      2'd0:    return 0;
      2'd1:    return 23;
      2'd2:    return 45;
      default: return 67;
    endcase
  endfunction

  task automatic decode_run();
    begin
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
      @(negedge clk);
      check_value("done", 32'(done), 32'd0, run_errors);
      while (done !== 1'b1)
        @(negedge clk);
      repeat (4) @(negedge clk);
      // done stays up once the FSM is back in idle
      check_value("done", 32'(done), 32'd1, run_errors);
      check_value("iteration toggles", 32'(iter_toggles), 32'(exp_iters), run_errors);
      check_value("first_iteration falls", 32'(first_iter_falls), 32'd1, run_errors);
      check_value("done rises", 32'(done_rises), 32'd1, run_errors);
      check_value("cn groups written", cn_seen ? 32'(cn_last) + 32'd1 : 32'd0,
                  32'(exp_groups), run_errors);
      // one closing step per half, two halves per iteration
      check_value("disable_vn steps", 32'(disable_vn_count), 32'(2 * exp_iters),
                  run_errors);
      check_value("disable_cn steps", 32'(disable_cn_count), 32'(2 * exp_iters),
                  run_errors);
    end
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    start      = 1'b0;
    mode       = '0;
    iter_limit = '0;
    for (int a = 0; a < ROM_WORDS; a++)
      rom[a] = ROM_DW'(a % NUM_INST);
    $readmemh("tests/ldpc_input.txt", rom);
    mode       = rom[CFG_BASE][4:0];
    iter_limit = rom[CFG_BASE+1][5:0];
    exp_groups = int'(rom[CFG_BASE+2]);
    exp_iters  = int'(rom[CFG_BASE+3]);
    // long-frame flag of the pointer word picks the initial parity VN address
    exp_vn_start = rom[ROM_AW'(mode)][15] ? VN_START_LONG : VN_START_SHORT;
    cfg_loaded = 1'b1;

    @(posedge clk);
    @(negedge clk);
    check_value("done", 32'(done), 32'd0, run_errors);
    check_value("we_vnmsg", 32'(we_vnmsg), 32'd0, run_errors);
    check_value("cn_we", 32'(cn_we), 32'd0, run_errors);
    check_value("cn_rd", 32'(cn_rd), 32'd0, run_errors);
    @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(negedge clk);
    check_value("done", 32'(done), 32'd1, run_errors);

    for (int r = 0; r < RUNS; r++)
      decode_run();

    repeat (2) @(posedge clk);
    $display("errors: %0d in run checks, %0d in cycle checks", run_errors, watch_errors);
    if (run_errors == 0 && watch_errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // per-cycle protocol and shift checks, sampled away from the clock edge
  always @(negedge clk)
  begin
    int shift_sum;
    // shift0 leads shift1 and shift2 by two register stages
    shift_sum = bin_start(shift0_d2) + 3 * int'(shifts.shift1) + int'(shifts.shift2);
    if (!rst)
    begin
      check_rule(!(cn_we && we_vnmsg), "cn_we and we_vnmsg are high in the same cycle",
                 watch_errors);
      if (cn_we)
        check_rule(first_half, "cn_we is high outside the CN half", watch_errors);
      if (cn_rd)
        check_rule(!first_half, "cn_rd is high outside the VN half", watch_errors);
      if (we_vnmsg)
        check_rule(!first_half, "we_vnmsg is high outside the VN half", watch_errors);
      check_limit("shift2", int'(shifts.shift2), 2, watch_errors);
      check_limit("shift sum", shift_sum, NUM_INST - 1, watch_errors);
      // the step that closes the parity chain writes the initial parity VN
      if (disable_vn)
      begin
        check_value("addr_vn", 32'(addr_vn), 32'(exp_vn_start), watch_errors);
        disable_vn_count++;
      end
      // and belongs to the first CN group
      if (disable_cn)
      begin
        check_value("addr_cn", 32'(addr_cn), 32'd0, watch_errors);
        disable_cn_count++;
      end
      // CN groups are written in order during the first CN half
      if (cn_we && first_iteration)
      begin
        if (!cn_seen)
          check_value("addr_cn", 32'(addr_cn), 32'd0, watch_errors);
        else if (addr_cn != cn_last)
          check_value("addr_cn", 32'(addr_cn), 32'(cn_last + 1'b1), watch_errors);
        cn_seen = 1'b1;
        cn_last = addr_cn;
      end
      if (start)
      begin
        iter_toggles     = 0;
        first_iter_falls = 0;
        done_rises       = 0;
        disable_vn_count = 0;
        disable_cn_count = 0;
        cn_seen          = 1'b0;
      end
      else
      begin
        if (iteration !== prev_iteration)
          iter_toggles++;
        if (prev_first_iter && !first_iteration)
          first_iter_falls++;
        if (!prev_done && done)
          done_rises++;
      end
    end
    shift0_d2       = shift0_d1;
    shift0_d1       = shifts.shift0;
    prev_iteration  = iteration;
    prev_first_iter = first_iteration;
    prev_done       = done;
  end

  // limit scales with the iterations and groups of the loaded schedule
  initial
  begin
    int limit_cycles;
    wait (cfg_loaded);
    limit_cycles = (int'(iter_limit) + 1) * exp_groups * 64;
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired before the decode runs finished");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* tests/ldpc_iocontrol_assertions.sv */
`timescale 1ns/10ps

module ldpc_iocontrol_assertions
  import ldpc_ctrl_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        start,
  input logic        done,
  input logic        first_half,
  input logic        cn_we,
  input logic        cn_rd,
  input logic        we_vnmsg,
  input shift_ctrl_t shifts
);

  // CN writes and VN message writes belong to opposite halves
  write_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(cn_we && we_vnmsg))
    else $error("cn_we and we_vnmsg high together");

  cn_write_half: assert property (@(posedge clk) disable iff (rst)
    cn_we |-> first_half)
    else $error("cn_we outside the CN half");

  cn_read_half: assert property (@(posedge clk) disable iff (rst)
    cn_rd |-> !first_half)
    else $error("cn_rd outside the VN half");

  // start is only taken in idle, where done is high
  done_drop: assert property (@(posedge clk) disable iff (rst)
    (start && done) |=> !done)
    else $error("done did not drop after start");

  shift2_range: assert property (@(posedge clk) disable iff (rst)
    shifts.shift2 <= 3'd2)
    else $error("shift2 above 2");

endmodule

/* hdl/ldpc_iocontrol.sv */
`timescale 1ns/10ps

module ldpc_iocontrol
  import ldpc_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [4:0]        mode,
  input  logic [5:0]        iter_limit,
  output logic              done,
  output logic              iteration,
  output logic              first_iteration,
  output logic              first_half,
  output logic              we_vnmsg,
  output logic [VN_AW-1:0]  addr_vn,
  output logic              disable_vn,
  output logic              cn_we,
  output logic              cn_rd,
  output logic [CN_AW-1:0]  addr_cn,
  output logic              disable_cn,
  output shift_ctrl_t       shifts,
  output logic [ROM_AW-1:0] romaddr,
  input  rom_word_u         romdata
);

  ctrl_word_t         ctrl;
  group_cmd_t         cmd;
  logic               load_cmd;
  logic               keep_cmd;
  logic [SHIFT_W-1:0] shift_raw;

  ldpc_schedule_fsm fsm_i (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .mode            (mode),
    .iter_limit      (iter_limit),
    .romdata         (romdata),
    .cmd             (cmd),
    .romaddr         (romaddr),
    .load_cmd        (load_cmd),
    .keep_cmd        (keep_cmd),
    .ctrl            (ctrl),
    .first_half      (first_half),
    .iteration       (iteration),
    .first_iteration (first_iteration),
    .done            (done)
  );

  ldpc_group_regs group_regs_i (
    .clk      (clk),
    .rst      (rst),
    .romdata  (romdata),
    .load_cmd (load_cmd),
    .keep_cmd (keep_cmd),
    .cmd      (cmd)
  );

  ldpc_latency_align align_i (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .first_half (first_half),
    .we_vnmsg   (we_vnmsg),
    .addr_vn    (addr_vn),
    .disable_vn (disable_vn),
    .cn_we      (cn_we),
    .cn_rd      (cn_rd),
    .addr_cn    (addr_cn),
    .disable_cn (disable_cn),
    .shift_raw  (shift_raw)
  );

  ldpc_shift_split split_i (
    .clk       (clk),
    .rst       (rst),
    .shift_raw (shift_raw),
    .shifts    (shifts)
  );

endmodule

/* hdl/ldpc_shift_split.sv */
`timescale 1ns/10ps

module ldpc_shift_split
  import ldpc_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [SHIFT_W-1:0] shift_raw,
  output shift_ctrl_t        shifts
);

  logic [1:0]         shift0_d;
  logic [SHIFT_W-1:0] rem0_d;
  logic [SHIFT_W-1:0] rem0_q;
  logic [SHIFT_W-1:0] rem0_q2;
  logic [SHIFT_W-1:0] quo;
  logic [2:0]         shift1_q;
  logic [SHIFT_W-1:0] rem1_d;

  // coarse stage picks one of four bins of the 90-wide range
  always_comb
  begin
    shift0_d = 2'd0;
    for (int i = 0; i < 3; i++)
      if (shift_raw > SHIFT0_BOUND[i])
        shift0_d = 2'(i + 1);
    rem0_d = shift_raw - SHIFT0_OFFSET[shift0_d];
  end

  assign quo    = rem0_q / SHIFT_W'(SHIFT1_STEP);
  assign rem1_d = rem0_q2 - SHIFT_W'(SHIFT1_STEP * shift1_q);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      shifts   <= '0;
      rem0_q   <= '0;
      rem0_q2  <= '0;
      shift1_q <= '0;
    end
    else
    begin
      shifts.shift0 <= shift0_d;
      rem0_q        <= rem0_d;
      // middle stage in steps of 3, saturating at 7
      shift1_q      <= (quo > 7) ? 3'd7 : quo[2:0];
      rem0_q2       <= rem0_q;
      shifts.shift1 <= shift1_q;
      shifts.shift2 <= rem1_d[2:0];
    end
  end

endmodule

/* hdl/ldpc_latency_align.sv */
`timescale 1ns/10ps

module ldpc_latency_align
  import ldpc_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  ctrl_word_t         ctrl,
  input  logic               first_half,
  output logic               we_vnmsg,
  output logic [VN_AW-1:0]   addr_vn,
  output logic               disable_vn,
  output logic               cn_we,
  output logic               cn_rd,
  output logic [CN_AW-1:0]   addr_cn,
  output logic               disable_cn,
  output logic [SHIFT_W-1:0] shift_raw
);

  ctrl_word_t         vn_line    [LAT_VN];
  ctrl_word_t         cn_line    [LAT_CN];
  logic [SHIFT_W-1:0] shift_line [LAT_SHIFT_MAX];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < LAT_VN; i++)
        vn_line[i] <= '0;
      for (int i = 0; i < LAT_CN; i++)
        cn_line[i] <= '0;
      for (int i = 0; i < LAT_SHIFT_MAX; i++)
        shift_line[i] <= '0;
    end
    else
    begin
      vn_line[0]    <= ctrl;
      cn_line[0]    <= ctrl;
      shift_line[0] <= ctrl.shift;
      for (int i = 1; i < LAT_VN; i++)
        vn_line[i] <= vn_line[i-1];
      for (int i = 1; i < LAT_CN; i++)
        cn_line[i] <= cn_line[i-1];
      for (int i = 1; i < LAT_SHIFT_MAX; i++)
        shift_line[i] <= shift_line[i-1];

      // the side not served in this half restarts at its output tap
      if (first_half)
        vn_line[LAT_VN-1] <= ctrl;
      else
        cn_line[LAT_CN-1] <= ctrl;

      // downlink shifts see the full VN depth, uplink the shorter CN depth
      if (first_half)
        shift_line[LAT_SHIFT_MAX-1] <= shift_line[LAT_SHIFT_DL-2];
      else
        shift_line[LAT_SHIFT_MAX-1] <= shift_line[LAT_SHIFT_UL-2];
    end
  end

  assign we_vnmsg   = vn_line[LAT_VN-1].we_vnmsg;
  assign addr_vn    = vn_line[LAT_VN-1].vn_addr;
  assign disable_vn = vn_line[LAT_VN-1].disable_step;

  assign cn_we      = cn_line[LAT_CN-1].cn_we;
  assign cn_rd      = cn_line[LAT_CN-1].cn_rd;
  assign addr_cn    = cn_line[LAT_CN-1].cn_addr;
  assign disable_cn = cn_line[LAT_CN-1].disable_step;

  assign shift_raw = shift_line[LAT_SHIFT_MAX-1];

endmodule

/* hdl/ldpc_schedule_fsm.sv */
`timescale 1ns/10ps

module ldpc_schedule_fsm
  import ldpc_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic [4:0]        mode,
  input  logic [5:0]        iter_limit,
  input  rom_word_u         romdata,
  input  group_cmd_t        cmd,
  output logic [ROM_AW-1:0] romaddr,
  output logic              load_cmd,
  output logic              keep_cmd,
  output ctrl_word_t        ctrl,
  output logic              first_half,
  output logic              iteration,
  output logic              first_iteration,
  output logic              done
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_PREP0,
    S_PREP1,
    S_FETCH0,
    S_FETCH1,
    S_PARITY_SHIFTED,
    S_MSG,
    S_PARITY,
    S_DRAIN,
    S_RESTART
  } state_e;

  state_e            state;
  logic [CN_AW-1:0]  cn_count;
  logic [VN_AW-1:0]  vn_count;
  logic [CN_AW-1:0]  ta_count;
  logic [ROM_AW-1:0] start_addr;
  logic [ROM_AW-1:0] turnaround_addr;
  logic [4:0]        count;
  logic [5:0]        iter_count;
  logic [3:0]        wait_count;
  logic              first_group;
  logic              long_frame;
  logic [VN_AW-1:0]  vn_start;
  logic              we;
  logic              matchpar;
  logic              last_step;

  assign vn_start = long_frame ? VN_AW'(VN_START_LONG) : VN_AW'(VN_START_SHORT);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state           <= S_IDLE;
      romaddr         <= '0;
      done            <= 1'b0;
      iteration       <= 1'b0;
      first_iteration <= 1'b0;
      first_half      <= 1'b0;
      cn_count        <= '0;
      vn_count        <= '0;
      ta_count        <= '0;
      start_addr      <= '0;
      turnaround_addr <= '0;
      count           <= '0;
      iter_count      <= '0;
      wait_count      <= '0;
      first_group     <= 1'b0;
      long_frame      <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        // mode selects a pointer word in the ROM
        S_IDLE:
        begin
          if (start)
            state <= S_PREP0;
          romaddr         <= ROM_AW'(mode);
          iter_count      <= iter_limit;
          first_iteration <= 1'b1;
          first_half      <= 1'b1;
          cn_count        <= '0;
          vn_count        <= '0;
          ta_count        <= '0;
          first_group     <= 1'b1;
          done            <= ~start;
        end
        S_PREP0:
          state <= S_PREP1;
        // pointer word is on the ROM output now
        S_PREP1:
        begin
          state           <= S_FETCH0;
          long_frame      <= romdata.ptr.long_frame;
          romaddr         <= romdata.ptr.start_addr;
          start_addr      <= romdata.ptr.start_addr;
          turnaround_addr <= romdata.ptr.start_addr;
        end
        S_FETCH0:
        begin
          state    <= S_FETCH1;
          vn_count <= vn_start;
        end
        // group command is captured by the register block here
        S_FETCH1:
        begin
          state   <= S_PARITY_SHIFTED;
          romaddr <= romaddr + 1'b1;
          count   <= '0;
        end
        S_PARITY_SHIFTED:
        begin
          state       <= S_MSG;
          romaddr     <= romaddr + 1'b1;
          wait_count  <= 4'(TA_WAIT);
          first_group <= 1'b0;
        end
        // one edge entry per cycle
        S_MSG:
        begin
          if (count == cmd.depth)
            state <= S_PARITY;
          else
            romaddr <= romaddr + 1'b1;
          count    <= count + 1'b1;
          vn_count <= cmd.q + cn_count;
        end
        S_PARITY:
        begin
          if (cmd.last_group || cmd.turnaround)
          begin
            state <= S_DRAIN;
          end
          else
          begin
            state    <= S_PARITY_SHIFTED;
            cn_count <= cn_count + 1'b1;
            romaddr  <= romaddr + 1'b1;
            count    <= '0;
          end
        end
        S_DRAIN:
        begin
          wait_count <= wait_count - 1'b1;
          if (wait_count == 0)
          begin
            if (cmd.last_group && !first_half && iter_count == 0)
            begin
              state <= S_IDLE;
              done  <= 1'b1;
            end
            else
            begin
              state <= S_RESTART;
            end
            // swap to the other half of the same segment
            cn_count        <= ta_count;
            romaddr         <= turnaround_addr;
            ta_count        <= cn_count + 1'b1;
            turnaround_addr <= romaddr;
            // end of a VN half on the last group closes the iteration
            if (cmd.last_group && !first_half)
            begin
              cn_count        <= '0;
              iteration       <= ~iteration;
              first_iteration <= 1'b0;
              romaddr         <= start_addr;
              iter_count      <= iter_count - 1'b1;
              ta_count        <= '0;
              turnaround_addr <= start_addr;
            end
          end
        end
        S_RESTART:
        begin
          state <= S_FETCH1;
          if (cn_count == 0)
          begin
            first_group <= 1'b1;
            vn_count    <= vn_start;
          end
          first_half <= ~first_half;
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  always_comb
  begin
    we        = 1'b0;
    matchpar  = 1'b0;
    last_step = 1'b0;
    case (state)
      S_MSG:
        we = 1'b1;
      S_PARITY:
      begin
        we       = 1'b1;
        matchpar = 1'b1;
      end
      // first group wraps the parity chain, the others write the next CN
      S_PARITY_SHIFTED:
      begin
        we = 1'b1;
        if (first_group)
          last_step = 1'b1;
        else
          matchpar = 1'b1;
      end
      default:
        we = 1'b0;
    endcase
  end

  always_comb
  begin
    ctrl.vn_addr = (matchpar || last_step) ? vn_count : romdata.entry.vn_addr;
    ctrl.cn_addr = cn_count;
    if (matchpar)
      ctrl.shift = '0;
    else if (last_step)
      ctrl.shift = first_half ? SHIFT_W'(1) : SHIFT_W'(NUM_INST - 1);
    else if (first_half)
      ctrl.shift = romdata.entry.shift;
    else if (romdata.entry.shift == 0)
      ctrl.shift = '0;
    else
      ctrl.shift = SHIFT_W'(NUM_INST) - romdata.entry.shift;
    ctrl.we_vnmsg     = we & ~first_half;
    ctrl.cn_we        = we & first_half;
    ctrl.cn_rd        = we & ~first_half;
    ctrl.disable_step = last_step;
  end

  assign load_cmd = (state == S_FETCH1) ||
                    (state == S_PARITY && !cmd.last_group && !cmd.turnaround);
  assign keep_cmd = (state != S_IDLE);

endmodule

/* hdl/ldpc_group_regs.sv */
`timescale 1ns/10ps

module ldpc_group_regs
  import ldpc_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  rom_word_u  romdata,
  input  logic       load_cmd,
  input  logic       keep_cmd,
  output group_cmd_t cmd
);

  // current group descriptor, valid from the fetch through the drain
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      cmd <= '0;
    end
    else if (load_cmd)
    begin
      cmd <= romdata.grp.cmd;
    end
    else if (!keep_cmd)
    begin
      // nothing in flight, drop the old group
      cmd <= '0;
    end
  end

endmodule

/* hdl/ldpc_ctrl_pkg.sv */
package ldpc_ctrl_pkg;

  // bus widths
  localparam int ROM_AW  = 13;
  localparam int ROM_DW  = 16;
  localparam int VN_AW   = 8;
  localparam int CN_AW   = 8;
  localparam int SHIFT_W = 8;

  // fold factor 4, so 90 instances per fold
  localparam int NUM_INST = 90;

  // initial parity VN address for short and long frames
  localparam int VN_START_SHORT = 44;
  localparam int VN_START_LONG  = 179;

  // wait states to let the pipeline drain between halves
  localparam int TA_WAIT = 11;

  // pipeline depths of the surrounding datapath
  localparam int LOCAL_DELAY   = 1;
  localparam int RAM_LATENCY   = 2;
  localparam int VN_PIPES      = 3;
  localparam int SHUFFLE_PIPES = 3;
  localparam int CN_PIPES      = 2;

  localparam int LAT_VN = LOCAL_DELAY + RAM_LATENCY + SHUFFLE_PIPES + CN_PIPES;
  localparam int LAT_CN = LOCAL_DELAY + RAM_LATENCY + SHUFFLE_PIPES + VN_PIPES;

  // shift values go to the shuffler, which sits after VN or CN only
  localparam int LAT_SHIFT_DL  = LOCAL_DELAY + RAM_LATENCY + VN_PIPES;
  localparam int LAT_SHIFT_UL  = LOCAL_DELAY + RAM_LATENCY + CN_PIPES;
  localparam int LAT_SHIFT_MAX = LOCAL_DELAY + RAM_LATENCY +
                                 ((VN_PIPES > CN_PIPES) ? VN_PIPES : CN_PIPES);

  // stage-0 split: last value of each bin, and the bin start
  localparam logic [2:0][SHIFT_W-1:0] SHIFT0_BOUND  = {SHIFT_W'(66), SHIFT_W'(44),
                                                       SHIFT_W'(22)};
  localparam logic [3:0][SHIFT_W-1:0] SHIFT0_OFFSET = {SHIFT_W'(67), SHIFT_W'(45),
                                                       SHIFT_W'(23), SHIFT_W'(0)};

  localparam int SHIFT1_STEP = 3;

  typedef struct packed {
    logic       turnaround;
    logic       last_group;
    logic [4:0] depth;
    logic [7:0] q;
  } group_cmd_t;

  // ROM views
  typedef struct packed {
    logic              long_frame;
    logic [1:0]        spare;
    logic [ROM_AW-1:0] start_addr;
  } rom_ptr_t;

  typedef struct packed {
    logic       spare;
    group_cmd_t cmd;
  } rom_grp_t;

  typedef struct packed {
    logic [VN_AW-1:0]   vn_addr;
    logic [SHIFT_W-1:0] shift;
  } rom_entry_t;

  typedef union packed {
    rom_ptr_t   ptr;
    rom_grp_t   grp;
    rom_entry_t entry;
  } rom_word_u;

  typedef struct packed {
    logic [VN_AW-1:0]   vn_addr;
    logic [CN_AW-1:0]   cn_addr;
    logic [SHIFT_W-1:0] shift;
    logic               we_vnmsg;
    logic               cn_we;
    logic               cn_rd;
    logic               disable_step;
  } ctrl_word_t;

  typedef struct packed {
    logic [1:0] shift0;
    logic [2:0] shift1;
    logic [2:0] shift2;
  } shift_ctrl_t;

endpackage
